// ==== logic/bpu_pkg.sv ====
package bpu_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    // Default table index width, history is the same length
    localparam int INDEX_BITS = 8;

    // Branch PCs fetch can present per cycle
    localparam int SLOTS = 2;

    localparam int PC_BITS       = 32;
    localparam int CFG_DATA_BITS = 32;

    ////////////////////////////////////////
    // Register map
    ////////////////////////////////////////

    localparam logic [1:0] CFG_ADDR_MODE     = 2'd0;
    localparam logic [1:0] CFG_ADDR_BRANCHES = 2'd1;
    localparam logic [1:0] CFG_ADDR_MISSES   = 2'd2;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    typedef logic [PC_BITS-1:0] pc_t;

    typedef enum logic {
        MODE_BIMODAL = 1'b0,
        MODE_GSHARE  = 1'b1
    } bpu_mode_t;

    // One fetch group of branch PCs
    typedef struct packed {
        logic                 valid;
        pc_t [SLOTS-1:0]      pc;
    } pred_req_t;

    // Resolved branch from the back end
    typedef struct packed {
        logic valid;
        pc_t  pc;
        logic taken;
        logic predicted;
    } br_update_t;

    typedef struct packed {
        logic                     wr;
        logic                     rd;
        logic [1:0]               addr;
        logic [CFG_DATA_BITS-1:0] wdata;
    } cfg_req_t;

endpackage

// ==== logic/pattern_table.sv ====
module pattern_table #(
    parameter int INDEX_BITS = 8
) (
    input  logic                                      clk,
    input  logic                                      rst,

    // Read side, one index per fetch slot
    input  logic [bpu_pkg::SLOTS-1:0][INDEX_BITS-1:0] rd_index,

    // Update side from the resolved branch
    input  logic                                      upd_valid,
    input  logic                                      upd_taken,
    input  logic [INDEX_BITS-1:0]                     up_index,

    output logic [bpu_pkg::SLOTS-1:0]                 predict
);

    localparam int ENTRIES = 1 << INDEX_BITS;

    // Counter encoding
    localparam logic [1:0] STRONG_NT = 2'b00;
    localparam logic [1:0] WEAK_NT   = 2'b01;
    localparam logic [1:0] WEAK_T    = 2'b10;
    localparam logic [1:0] STRONG_T  = 2'b11;

    logic [1:0] pht [ENTRIES];
    logic [1:0] up_cnt;
    logic [1:0] up_next;

    ////////////////////////////////////////
    // Saturating counter step
    ////////////////////////////////////////

    function automatic logic [1:0] counter_step(
        input logic [1:0] cnt,
        input logic       taken
    );
        logic [1:0] nxt;
        nxt = cnt;
        if (taken) begin
            case (cnt)
                STRONG_NT: nxt = WEAK_NT;
                WEAK_NT:   nxt = WEAK_T;
                WEAK_T:    nxt = STRONG_T;
                default:   nxt = STRONG_T;
            endcase
        end else begin
            case (cnt)
                STRONG_T:  nxt = WEAK_T;
                WEAK_T:    nxt = WEAK_NT;
                WEAK_NT:   nxt = STRONG_NT;
                default:   nxt = STRONG_NT;
            endcase
        end
        return nxt;
    endfunction

    assign up_cnt  = pht[up_index];
    assign up_next = counter_step(up_cnt, upd_taken);

    ////////////////////////////////////////
    // Prediction read
    ////////////////////////////////////////

    // Upper counter bit is the guess, registered per slot
    // Nonblocking write below means a same-cycle read sees the old counter
    generate
        for (genvar s = 0; s < bpu_pkg::SLOTS; s++) begin : g_slot
            always_ff @(posedge clk) begin
                if (rst) begin
                    predict[s] <= 1'b0;
                end else begin
                    predict[s] <= pht[rd_index[s]][1];
                end
            end
        end
    endgenerate

    ////////////////////////////////////////
    // Counter update
    ////////////////////////////////////////

    // Table starts at strongly not taken
    always_ff @(posedge clk) begin
        if (rst) begin
            pht <= '{default: STRONG_NT};
        end else if (upd_valid) begin
            pht[up_index] <= up_next;
        end
    end

endmodule

// ==== logic/history_index.sv ====
module history_index #(
    parameter int INDEX_BITS = 8
) (
    input  logic                                      clk,
    input  logic                                      rst,

    // Fetch PCs, one per slot
    input  bpu_pkg::pc_t [bpu_pkg::SLOTS-1:0]         req_pc,

    // Resolved branch
    input  logic                                      upd_valid,
    input  logic                                      upd_taken,
    input  bpu_pkg::pc_t                              upd_pc,

    // Steering from the config block
    input  bpu_pkg::bpu_mode_t                        mode,
    input  logic                                      hist_clear,

    output logic [bpu_pkg::SLOTS-1:0][INDEX_BITS-1:0] rd_index,
    output logic [INDEX_BITS-1:0]                     up_index
);

    // Global history, newest outcome in bit 0
    logic [INDEX_BITS-1:0] history;

    // History as seen by the hash, zero in bimodal mode
    logic [INDEX_BITS-1:0] hist_mix;

    ////////////////////////////////////////
    // Global history register
    ////////////////////////////////////////

    // Clear wins over a shift in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            history <= '0;
        end else if (hist_clear) begin
            history <= '0;
        end else if (upd_valid) begin
            history <= {history[INDEX_BITS-2:0], upd_taken};
        end
    end

    ////////////////////////////////////////
    // Index generation
    ////////////////////////////////////////

    assign hist_mix = (mode == bpu_pkg::MODE_GSHARE) ? history : '0;

    // Word-aligned PC bits hashed with history
    generate
        for (genvar s = 0; s < bpu_pkg::SLOTS; s++) begin : g_rd_idx
            assign rd_index[s] = req_pc[s][INDEX_BITS+1:2] ^ hist_mix;
        end
    endgenerate

    // Update uses the same history the fetch side sees
    // since history only moves at resolve time
    assign up_index = upd_pc[INDEX_BITS+1:2] ^ hist_mix;

endmodule

// ==== logic/bpu_config.sv ====
module bpu_config (
    input  logic                                clk,
    input  logic                                rst,

    input  bpu_pkg::cfg_req_t                   cfg,
    input  bpu_pkg::br_update_t                 upd,

    output bpu_pkg::bpu_mode_t                  mode,
    output logic                                hist_clear,
    output logic [bpu_pkg::CFG_DATA_BITS-1:0]   cfg_rdata
);

    localparam logic [bpu_pkg::CFG_DATA_BITS-1:0] CNT_ONE = 1;

    logic mode_wr;
    logic mispredict;

    logic [bpu_pkg::CFG_DATA_BITS-1:0] branch_cnt;
    logic [bpu_pkg::CFG_DATA_BITS-1:0] miss_cnt;

    ////////////////////////////////////////
    // Mode register and history clear
    ////////////////////////////////////////

    assign mode_wr = cfg.wr && (cfg.addr == bpu_pkg::CFG_ADDR_MODE);

    // Bit 0 selects the mode, bit 1 requests a history clear
    always_ff @(posedge clk) begin
        if (rst) begin
            mode <= bpu_pkg::MODE_BIMODAL;
        end else if (mode_wr) begin
            mode <= bpu_pkg::bpu_mode_t'(cfg.wdata[0]);
        end
    end

    // Pulse lands on the same edge as the write
    assign hist_clear = mode_wr && cfg.wdata[1];

    ////////////////////////////////////////
    // Statistics
    ////////////////////////////////////////

    assign mispredict = upd.valid && (upd.taken != upd.predicted);

    // Both counters wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            branch_cnt <= '0;
            miss_cnt   <= '0;
        end else begin
            if (upd.valid) begin
                branch_cnt <= branch_cnt + CNT_ONE;
            end
            if (mispredict) begin
                miss_cnt <= miss_cnt + CNT_ONE;
            end
        end
    end

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (cfg.rd) begin
            case (cfg.addr)
                bpu_pkg::CFG_ADDR_MODE:     cfg_rdata <= {{(bpu_pkg::CFG_DATA_BITS-1){1'b0}}, mode};
                bpu_pkg::CFG_ADDR_BRANCHES: cfg_rdata <= branch_cnt;
                bpu_pkg::CFG_ADDR_MISSES:   cfg_rdata <= miss_cnt;
                default:                    cfg_rdata <= '0;
            endcase
        end
    end

endmodule

// ==== logic/branch_predictor.sv ====
module branch_predictor #(
    parameter int INDEX_BITS = bpu_pkg::INDEX_BITS
) (
    input  logic                                clk,
    input  logic                                rst,

    // Fetch side
    input  bpu_pkg::pred_req_t                  req,
    output logic [bpu_pkg::SLOTS-1:0]           predict,
    output logic                                pred_valid,

    // Resolve side
    input  bpu_pkg::br_update_t                 upd,

    // Software access
    input  bpu_pkg::cfg_req_t                   cfg,
    output logic [bpu_pkg::CFG_DATA_BITS-1:0]   cfg_rdata
);

    bpu_pkg::bpu_mode_t mode;
    logic               hist_clear;

    logic [bpu_pkg::SLOTS-1:0][INDEX_BITS-1:0] rd_index;
    logic [INDEX_BITS-1:0]                     up_index;

    ////////////////////////////////////////
    // Config and statistics
    ////////////////////////////////////////

    bpu_config bpu_config_inst (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .upd        (upd),
        .mode       (mode),
        .hist_clear (hist_clear),
        .cfg_rdata  (cfg_rdata)
    );

    ////////////////////////////////////////
    // History and table indexing
    ////////////////////////////////////////

    history_index #(
        .INDEX_BITS (INDEX_BITS)
    ) history_index_inst (
        .clk        (clk),
        .rst        (rst),
        .req_pc     (req.pc),
        .upd_valid  (upd.valid),
        .upd_taken  (upd.taken),
        .upd_pc     (upd.pc),
        .mode       (mode),
        .hist_clear (hist_clear),
        .rd_index   (rd_index),
        .up_index   (up_index)
    );

    pattern_table #(
        .INDEX_BITS (INDEX_BITS)
    ) pattern_table_inst (
        .clk        (clk),
        .rst        (rst),
        .rd_index   (rd_index),
        .upd_valid  (upd.valid),
        .upd_taken  (upd.taken),
        .up_index   (up_index),
        .predict    (predict)
    );

    // Valid lines up with the registered table read
    always_ff @(posedge clk) begin
        if (rst) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= req.valid;
        end
    end

endmodule

// ==== sim/bpu_asserts.sv ====
module bpu_asserts (
    input logic                      clk,
    input logic                      rst,
    input bpu_pkg::pred_req_t        req,
    input bpu_pkg::cfg_req_t         cfg,
    input logic [bpu_pkg::SLOTS-1:0] predict,
    input logic                      pred_valid
);

    // Failed assertion count
    int assert_failures = 0;

    valid_after_reset: assert property (@(posedge clk) rst |=> !pred_valid)
        else begin
            assert_failures++;
            $error("pred_valid set in the cycle after reset");
        end

    // One cycle of latency, no more and no less
    valid_follows_req: assert property (@(posedge clk) disable iff (rst)
        !rst |=> (pred_valid == $past(req.valid)))
        else begin
            assert_failures++;
            $error("pred_valid does not follow req.valid by one cycle");
        end

    predict_known: assert property (@(posedge clk) disable iff (rst)
        pred_valid |-> !$isunknown(predict))
        else begin
            assert_failures++;
            $error("predict has unknown bits while pred_valid is set");
        end

    cfg_one_strobe: assert property (@(posedge clk) disable iff (rst) !(cfg.wr && cfg.rd))
        else begin
            assert_failures++;
            $error("cfg.wr and cfg.rd set together");
        end

endmodule

bind branch_predictor bpu_asserts bpu_asserts_inst (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .cfg        (cfg),
    .predict    (predict),
    .pred_valid (pred_valid)
);

// ==== sim/tb_branch_predictor.sv ====
module tb_branch_predictor;

    localparam int IDX         = bpu_pkg::INDEX_BITS;
    localparam int DRIVE_DELAY = 2;
    localparam int WAIT_LIMIT  = 20;

    logic                              clk;
    logic                              rst;
    bpu_pkg::pred_req_t                req;
    bpu_pkg::br_update_t               upd;
    bpu_pkg::cfg_req_t                 cfg;
    logic [bpu_pkg::SLOTS-1:0]         predict;
    logic                              pred_valid;
    logic [bpu_pkg::CFG_DATA_BITS-1:0] cfg_rdata;

    int seed;
    int errors;
    int checks;
    int tests_run;
    int tests_failed;

    // Reference model of table, history and statistics
    logic [1:0]     model_pht [1 << IDX];
    logic [IDX-1:0] model_hist;
    logic           model_mode;
    logic [31:0]    model_branches;
    logic [31:0]    model_misses;

    branch_predictor #(
        .INDEX_BITS (IDX)
    ) branch_predictor_inst (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .predict    (predict),
        .pred_valid (pred_valid),
        .upd        (upd),
        .cfg        (cfg),
        .cfg_rdata  (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic logic [IDX-1:0] model_index(input bpu_pkg::pc_t pc);
        logic [IDX-1:0] h;
        h = model_mode ? model_hist : '0;
        return pc[IDX+1:2] ^ h;
    endfunction

    // Index from the old history, then the outcome shifts in
    task automatic model_update(input bpu_pkg::pc_t pc, input logic taken,
                                input logic predicted);
        logic [IDX-1:0] idx;
        idx = model_index(pc);
        if (taken && model_pht[idx] != 2'd3) begin
            model_pht[idx] = model_pht[idx] + 2'd1;
        end else if (!taken && model_pht[idx] != 2'd0) begin
            model_pht[idx] = model_pht[idx] - 2'd1;
        end
        model_hist     = {model_hist[IDX-2:0], taken};
        model_branches = model_branches + 32'd1;
        if (taken != predicted) begin
            model_misses = model_misses + 32'd1;
        end
    endtask

    ////////////////////////////////////////
    // Drivers and checks
    ////////////////////////////////////////

    task automatic next_edge();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic expect_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
        end
        $display("%s: %0d errors", name, errors - errors_before);
    endtask

    task automatic end_run();
        errors = errors + branch_predictor_inst.bpu_asserts_inst.assert_failures;
        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    // Small PC pool so counters get trained
    function automatic bpu_pkg::pc_t pool_pc();
        logic [31:0] r;
        r = $random(seed);
        return 32'h0000_0400 + {27'd0, r[2:0], 2'b00};
    endfunction

    task automatic apply_update(input bpu_pkg::pc_t pc, input logic taken,
                                input logic predicted);
        upd.valid     = 1'b1;
        upd.pc        = pc;
        upd.taken     = taken;
        upd.predicted = predicted;
        model_update(pc, taken, predicted);
        next_edge();
        upd.valid = 1'b0;
    endtask

    task automatic write_config(input logic [1:0] addr, input logic [31:0] wdata);
        cfg.wr    = 1'b1;
        cfg.addr  = addr;
        cfg.wdata = wdata;
        if (addr == bpu_pkg::CFG_ADDR_MODE) begin
            model_mode = wdata[0];
            if (wdata[1]) begin
                model_hist = '0;
            end
        end
        next_edge();
        cfg.wr = 1'b0;
    endtask

    // Read data is registered, one cycle after the strobe
    task automatic read_config(input logic [1:0] addr, output logic [31:0] data);
        cfg.rd   = 1'b1;
        cfg.addr = addr;
        next_edge();
        cfg.rd = 1'b0;
        data   = cfg_rdata;
    endtask

    // Request both slots, with an optional update in the same cycle
    task automatic predict_cycle(input string what, input bpu_pkg::pc_t pc0,
                                 input bpu_pkg::pc_t pc1, input bpu_pkg::br_update_t u,
                                 output logic [1:0] got);
        logic [1:0] exp;
        int         waited;
        exp[0]    = model_pht[model_index(pc0)][1];
        exp[1]    = model_pht[model_index(pc1)][1];
        req.valid = 1'b1;
        req.pc[0] = pc0;
        req.pc[1] = pc1;
        upd       = u;
        if (u.valid) begin
            model_update(u.pc, u.taken, u.predicted);
        end
        waited = 0;
        do begin
            next_edge();
            req.valid = 1'b0;
            upd.valid = 1'b0;
            waited++;
        end while (!pred_valid && waited < WAIT_LIMIT);
        if (!pred_valid) begin
            errors++;
            $display("Timeout: no prediction came back for %s", what);
            got = 'x;
        end else begin
            got = predict;
            expect_value(what, {30'd0, predict}, {30'd0, exp});
            expect_value("prediction latency", waited, 32'd1);
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic reset_predictions();
        int           err0;
        logic [1:0]   got;
        bpu_pkg::pc_t pc0;
        bpu_pkg::pc_t pc1;
        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            pc0 = bpu_pkg::pc_t'($random(seed));
            pc1 = bpu_pkg::pc_t'($random(seed));
            predict_cycle("reset prediction", pc0, pc1, '0, got);
            expect_value("not taken after reset", {30'd0, got}, 32'd0);
        end
        report_test("reset_predictions", err0);
    endtask

    task automatic bimodal_saturation();
        int           err0;
        logic [1:0]   got;
        bpu_pkg::pc_t pc;
        err0 = errors;
        pc   = 32'h0000_1040;
        for (int i = 0; i < 3; i++) begin
            apply_update(pc, 1'b1, 1'b0);
        end
        predict_cycle("bimodal trained", pc, pc, '0, got);
        expect_value("taken after three", {30'd0, got}, 32'd3);
        apply_update(pc, 1'b0, 1'b1);
        predict_cycle("bimodal one down", pc, pc, '0, got);
        expect_value("still taken", {30'd0, got}, 32'd3);
        apply_update(pc, 1'b0, 1'b1);
        apply_update(pc, 1'b0, 1'b1);
        predict_cycle("bimodal three down", pc, pc, '0, got);
        expect_value("not taken", {30'd0, got}, 32'd0);
        report_test("bimodal_saturation", err0);
    endtask

    task automatic gshare_random_mix();
        int                  err0;
        logic [1:0]          got;
        logic [31:0]         r;
        bpu_pkg::br_update_t u;
        err0 = errors;
        write_config(bpu_pkg::CFG_ADDR_MODE, 32'd1);
        for (int i = 0; i < 40; i++) begin
            r           = $random(seed);
            u.valid     = r[0];
            u.pc        = pool_pc();
            u.taken     = r[1] | r[2];
            u.predicted = r[3];
            predict_cycle("gshare random", pool_pc(), pool_pc(), u, got);
        end
        report_test("gshare_random_mix", err0);
    endtask

    task automatic slot_aliasing();
        int                  err0;
        logic [1:0]          got;
        bpu_pkg::pc_t        pc_a;
        bpu_pkg::pc_t        pc_b;
        bpu_pkg::br_update_t u;
        err0 = errors;
        pc_a = 32'h0000_0a0c;
        pc_b = 32'h0000_0b10;
        write_config(bpu_pkg::CFG_ADDR_MODE, 32'd0);
        for (int i = 0; i < 3; i++) begin
            apply_update(pc_b, 1'b1, 1'b1);
            apply_update(pc_a, 1'b0, 1'b0);
        end
        // Weakly taken, one step from flipping
        apply_update(pc_a, 1'b1, 1'b0);
        apply_update(pc_a, 1'b1, 1'b0);
        u = '{valid: 1'b1, pc: pc_a, taken: 1'b0, predicted: 1'b1};
        predict_cycle("aliased with update", pc_a, pc_a, u, got);
        expect_value("old counter on both slots", {30'd0, got}, 32'd3);
        predict_cycle("distinct slots", pc_a, pc_b, '0, got);
        expect_value("slot 0 flipped, slot 1 taken", {30'd0, got}, 32'd2);
        report_test("slot_aliasing", err0);
    endtask

    task automatic statistics_readback();
        int          err0;
        logic [31:0] data;
        err0 = errors;
        // Taken from bit 0, predicted from bit 1, three misses in six
        for (int i = 0; i < 6; i++) begin
            apply_update(pool_pc(), i[0], i[1]);
        end
        write_config(bpu_pkg::CFG_ADDR_MODE, 32'd1);
        read_config(bpu_pkg::CFG_ADDR_BRANCHES, data);
        expect_value("branch count", data, model_branches);
        read_config(bpu_pkg::CFG_ADDR_MISSES, data);
        expect_value("miss count", data, model_misses);
        read_config(bpu_pkg::CFG_ADDR_MODE, data);
        expect_value("mode readback", data, {31'd0, model_mode});
        read_config(2'd3, data);
        expect_value("unmapped address", data, 32'd0);
        report_test("statistics_readback", err0);
    endtask

    task automatic history_clear();
        int           err0;
        logic [1:0]   got;
        bpu_pkg::pc_t pc;
        bpu_pkg::pc_t pc_stale;
        err0     = errors;
        pc       = 32'h0000_0c00;
        // Index that a stale history of 8'h1f would give for pc
        pc_stale = 32'h0000_0c7c;
        write_config(bpu_pkg::CFG_ADDR_MODE, 32'd0);
        for (int i = 0; i < 3; i++) begin
            apply_update(pc_stale, 1'b0, 1'b0);
        end
        // Three not taken then five taken leave history at 8'h1f
        for (int i = 0; i < 5; i++) begin
            apply_update(pc, 1'b1, 1'b1);
        end
        write_config(bpu_pkg::CFG_ADDR_MODE, 32'd3);
        predict_cycle("after history clear", pc, pc ^ 32'h0000_0004, '0, got);
        expect_value("same as bimodal index", {31'd0, got[0]}, 32'd1);
        report_test("history_clear", err0);
    endtask

    initial begin
        seed           = 14716;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        rst            = 1'b1;
        req            = '0;
        upd            = '0;
        cfg            = '0;
        model_hist     = '0;
        model_mode     = 1'b0;
        model_branches = '0;
        model_misses   = '0;
        for (int i = 0; i < (1 << IDX); i++) begin
            model_pht[i] = 2'd0;
        end
        repeat (16) begin
            @(posedge clk);
        end
        #DRIVE_DELAY;
        rst = 1'b0;
        reset_predictions();
        bimodal_saturation();
        gshare_random_mix();
        slot_aliasing();
        statistics_readback();
        history_clear();
        end_run();
    end

endmodule

// ==== compile.f ====
logic/bpu_pkg.sv
logic/pattern_table.sv
logic/history_index.sv
logic/bpu_config.sv
logic/branch_predictor.sv
sim/bpu_asserts.sv
sim/tb_branch_predictor.sv

// ==== Makefile ====
TOP := tb_branch_predictor

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build with Verilator and run the testbench"
	@echo "  make clean  remove the build directory"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
